// ==== source/rs_pkg.sv ====
package rs_pkg;

    // Physical register number width
    localparam int PREG_BITS = 6;

    // Reorder buffer id width
    localparam int ROBID_BITS = 5;

    // Source operands per micro-op
    localparam int NUM_SOURCES = 2;

    // Source slot indices
    localparam int SRC1 = 0;
    localparam int SRC2 = 1;

    // Micro-op opcodes
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_shl = 3'd5,
        op_shr = 3'd6,
        op_mov = 3'd7
    } t_opcode;

    // Station entry occupancy
    typedef enum logic {
        ent_idle  = 1'b0,
        ent_valid = 1'b1
    } t_rs_ent_state;

endpackage

// ==== source/rs_reg_trk.sv ====
`timescale 1ns/10ps

module rs_reg_trk #(
    parameter int NUM_WRITES = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         alloc,
    input  logic [rs_pkg::PREG_BITS-1:0] alloc_preg,
    input  logic                         alloc_pend,
    input  logic [NUM_WRITES-1:0]        prf_wr_en,
    input  logic [rs_pkg::PREG_BITS-1:0] prf_wr_preg [NUM_WRITES-1:0],
    output logic                         ready
);
    import rs_pkg::*;

    logic [PREG_BITS-1:0] preg_q;
    logic                 pend_q;
    logic                 pend_nxt;
    logic                 alloc_hit;
    logic                 track_hit;

    // Compare every write port against both the incoming and the stored register
    always_comb begin
        alloc_hit = 1'b0;
        track_hit = 1'b0;
        for (int w = 0; w < NUM_WRITES; w++) begin
            if (prf_wr_en[w] && (prf_wr_preg[w] == alloc_preg)) begin
                alloc_hit = 1'b1;
            end
            if (prf_wr_en[w] && (prf_wr_preg[w] == preg_q)) begin
                track_hit = 1'b1;
            end
        end
    end

    // A write in the allocation cycle already satisfies the source
    always_comb begin
        pend_nxt = pend_q;
        if (alloc) begin
            pend_nxt = alloc_pend & ~alloc_hit;
        end else if (track_hit) begin
            pend_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= pend_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            preg_q <= alloc_preg;
        end
    end

    assign ready = ~pend_q;

endmodule

// ==== source/rs_entry.sv ====
`timescale 1ns/10ps

module rs_entry #(
    parameter int NUM_WRITES = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alloc,
    input  rs_pkg::t_opcode               disp_opcode,
    input  logic [rs_pkg::ROBID_BITS-1:0] disp_robid,
    input  logic [rs_pkg::PREG_BITS-1:0]  disp_pdst,
    input  logic [rs_pkg::PREG_BITS-1:0]  disp_psrc1,
    input  logic                          disp_psrc1_pend,
    input  logic [rs_pkg::PREG_BITS-1:0]  disp_psrc2,
    input  logic                          disp_psrc2_pend,
    input  logic [NUM_WRITES-1:0]         prf_wr_en,
    input  logic [rs_pkg::PREG_BITS-1:0]  prf_wr_preg [NUM_WRITES-1:0],
    input  logic                          gnt,
    output logic                          valid,
    output logic                          req,
    output rs_pkg::t_opcode               ent_opcode,
    output logic [rs_pkg::ROBID_BITS-1:0] ent_robid,
    output logic [rs_pkg::PREG_BITS-1:0]  ent_pdst
);
    import rs_pkg::*;

    t_rs_ent_state          state;
    t_rs_ent_state          state_nxt;
    logic [PREG_BITS-1:0]   src_preg [NUM_SOURCES-1:0];
    logic [NUM_SOURCES-1:0] src_pend;
    logic [NUM_SOURCES-1:0] src_ready;

    // Occupancy FSM that the issue grant frees
    always_comb begin
        state_nxt = state;
        case (state)
            ent_idle: begin
                if (alloc) begin
                    state_nxt = ent_valid;
                end
            end
            ent_valid: begin
                if (gnt) begin
                    state_nxt = ent_idle;
                end
            end
            default: state_nxt = ent_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ent_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign valid = (state == ent_valid);

    // Static fields of the micro-op
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_opcode <= disp_opcode;
            ent_robid  <= disp_robid;
            ent_pdst   <= disp_pdst;
        end
    end

    assign src_preg[SRC1] = disp_psrc1;
    assign src_pend[SRC1] = disp_psrc1_pend;
    assign src_preg[SRC2] = disp_psrc2;
    assign src_pend[SRC2] = disp_psrc2_pend;

    for (genvar s = 0; s < NUM_SOURCES; s++) begin : g_src_trk
        rs_reg_trk #(
            .NUM_WRITES(NUM_WRITES)
        ) u_trk (
            .clk        (clk),
            .reset      (reset),
            .alloc      (alloc),
            .alloc_preg (src_preg[s]),
            .alloc_pend (src_pend[s]),
            .prf_wr_en  (prf_wr_en),
            .prf_wr_preg(prf_wr_preg),
            .ready      (src_ready[s])
        );
    end

    // Ready to issue once every source has been written
    assign req = valid & (&src_ready);

endmodule

// ==== source/rs_alloc.sv ====
`timescale 1ns/10ps

module rs_alloc #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                   disp_valid,
    input  logic [NUM_ENTRIES-1:0] valid,
    output logic [NUM_ENTRIES-1:0] alloc,
    output logic                   rs_full
);

    logic [NUM_ENTRIES-1:0] free;
    logic [NUM_ENTRIES-1:0] first_free;
    logic                   found;

    assign free = ~valid;

    // Lowest-index idle entry wins
    always_comb begin
        first_free = '0;
        found      = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (free[i] && !found) begin
                first_free[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // Strobe only the chosen entry, and only on a dispatch
    assign alloc = first_free & {NUM_ENTRIES{disp_valid}};

    // No idle entry left
    assign rs_full = ~|free;

endmodule

// ==== source/rs_issue_select.sv ====
`timescale 1ns/10ps

module rs_issue_select #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [NUM_ENTRIES-1:0]        req,
    input  logic                          issue_stall,
    input  rs_pkg::t_opcode               ent_opcode [NUM_ENTRIES-1:0],
    input  logic [rs_pkg::ROBID_BITS-1:0] ent_robid  [NUM_ENTRIES-1:0],
    input  logic [rs_pkg::PREG_BITS-1:0]  ent_pdst   [NUM_ENTRIES-1:0],
    output logic [NUM_ENTRIES-1:0]        gnt,
    output logic                          issue_valid,
    output rs_pkg::t_opcode               issue_opcode,
    output logic [rs_pkg::ROBID_BITS-1:0] issue_robid,
    output logic [rs_pkg::PREG_BITS-1:0]  issue_pdst
);

    localparam int IDX_BITS = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    logic [IDX_BITS-1:0] gnt_idx;
    logic                gnt_any;

    // Fixed priority with entry 0 highest and no grant during a stall
    always_comb begin
        gnt     = '0;
        gnt_idx = '0;
        gnt_any = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (req[i] && !gnt_any && !issue_stall) begin
                gnt[i]  = 1'b1;
                gnt_idx = IDX_BITS'(i);
                gnt_any = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= gnt_any;
        end
    end

    // Issue packet of the granted entry
    always_ff @(posedge clk) begin
        if (gnt_any) begin
            issue_opcode <= ent_opcode[gnt_idx];
            issue_robid  <= ent_robid[gnt_idx];
            issue_pdst   <= ent_pdst[gnt_idx];
        end
    end

endmodule

// ==== source/rs_top.sv ====
`timescale 1ns/10ps

module rs_top #(
    parameter int NUM_ENTRIES = 4,
    parameter int NUM_WRITES  = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disp_valid,
    input  rs_pkg::t_opcode               disp_opcode,
    input  logic [rs_pkg::ROBID_BITS-1:0] disp_robid,
    input  logic [rs_pkg::PREG_BITS-1:0]  disp_pdst,
    input  logic [rs_pkg::PREG_BITS-1:0]  disp_psrc1,
    input  logic                          disp_psrc1_pend,
    input  logic [rs_pkg::PREG_BITS-1:0]  disp_psrc2,
    input  logic                          disp_psrc2_pend,
    input  logic [NUM_WRITES-1:0]         prf_wr_en,
    input  logic [rs_pkg::PREG_BITS-1:0]  prf_wr_preg [NUM_WRITES-1:0],
    input  logic                          issue_stall,
    output logic                          rs_full,
    output logic                          issue_valid,
    output rs_pkg::t_opcode               issue_opcode,
    output logic [rs_pkg::ROBID_BITS-1:0] issue_robid,
    output logic [rs_pkg::PREG_BITS-1:0]  issue_pdst
);
    import rs_pkg::*;

    logic [NUM_ENTRIES-1:0] alloc;
    logic [NUM_ENTRIES-1:0] valid;
    logic [NUM_ENTRIES-1:0] req;
    logic [NUM_ENTRIES-1:0] gnt;
    t_opcode                ent_opcode [NUM_ENTRIES-1:0];
    logic [ROBID_BITS-1:0]  ent_robid  [NUM_ENTRIES-1:0];
    logic [PREG_BITS-1:0]   ent_pdst   [NUM_ENTRIES-1:0];

    rs_alloc #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_alloc (
        .disp_valid(disp_valid),
        .valid     (valid),
        .alloc     (alloc),
        .rs_full   (rs_full)
    );

    // Dispatch fields go to every entry and the allocate strobe picks one
    for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
        rs_entry #(
            .NUM_WRITES(NUM_WRITES)
        ) u_entry (
            .clk            (clk),
            .reset          (reset),
            .alloc          (alloc[e]),
            .disp_opcode    (disp_opcode),
            .disp_robid     (disp_robid),
            .disp_pdst      (disp_pdst),
            .disp_psrc1     (disp_psrc1),
            .disp_psrc1_pend(disp_psrc1_pend),
            .disp_psrc2     (disp_psrc2),
            .disp_psrc2_pend(disp_psrc2_pend),
            .prf_wr_en      (prf_wr_en),
            .prf_wr_preg    (prf_wr_preg),
            .gnt            (gnt[e]),
            .valid          (valid[e]),
            .req            (req[e]),
            .ent_opcode     (ent_opcode[e]),
            .ent_robid      (ent_robid[e]),
            .ent_pdst       (ent_pdst[e])
        );
    end

    rs_issue_select #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_issue_select (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .issue_stall (issue_stall),
        .ent_opcode  (ent_opcode),
        .ent_robid   (ent_robid),
        .ent_pdst    (ent_pdst),
        .gnt         (gnt),
        .issue_valid (issue_valid),
        .issue_opcode(issue_opcode),
        .issue_robid (issue_robid),
        .issue_pdst  (issue_pdst)
    );

endmodule

// ==== tests/rs_tb.sv ====
`timescale 1ns/10ps

module rs_tb;
    import rs_pkg::*;

    localparam int    NUM_ENTRIES   = 4;
    localparam int    NUM_WRITES    = 2;
    localparam int    NUM_ROBIDS    = 1 << ROBID_BITS;
    localparam int    DRAIN_TIMEOUT = 100;
    localparam string TEST_FILE     = "tests/rs_tests.txt";

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  disp_valid;
    t_opcode               disp_opcode;
    logic [ROBID_BITS-1:0] disp_robid;
    logic [PREG_BITS-1:0]  disp_pdst;
    logic [PREG_BITS-1:0]  disp_psrc1;
    logic                  disp_psrc1_pend;
    logic [PREG_BITS-1:0]  disp_psrc2;
    logic                  disp_psrc2_pend;
    logic [NUM_WRITES-1:0] prf_wr_en;
    logic [PREG_BITS-1:0]  prf_wr_preg [NUM_WRITES-1:0];
    logic                  issue_stall;
    logic                  rs_full;
    logic                  issue_valid;
    t_opcode               issue_opcode;
    logic [ROBID_BITS-1:0] issue_robid;
    logic [PREG_BITS-1:0]  issue_pdst;

    // Station model, one slot per entry
    logic m_valid [NUM_ENTRIES];
    int   m_op    [NUM_ENTRIES];
    int   m_robid [NUM_ENTRIES];
    int   m_pdst  [NUM_ENTRIES];
    int   m_preg  [NUM_ENTRIES][NUM_SOURCES];
    logic m_pend  [NUM_ENTRIES][NUM_SOURCES];
    logic exp_iv;
    int   exp_op;
    int   exp_robid;
    int   exp_pdst;
    int   outstanding;
    int   disp_count  [NUM_ROBIDS];
    int   issue_count [NUM_ROBIDS];
    integer seed = 32'h8cfb5d7d;

    rs_top #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .NUM_WRITES (NUM_WRITES)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .disp_valid     (disp_valid),
        .disp_opcode    (disp_opcode),
        .disp_robid     (disp_robid),
        .disp_pdst      (disp_pdst),
        .disp_psrc1     (disp_psrc1),
        .disp_psrc1_pend(disp_psrc1_pend),
        .disp_psrc2     (disp_psrc2),
        .disp_psrc2_pend(disp_psrc2_pend),
        .prf_wr_en      (prf_wr_en),
        .prf_wr_preg    (prf_wr_preg),
        .issue_stall    (issue_stall),
        .rs_full        (rs_full),
        .issue_valid    (issue_valid),
        .issue_opcode   (issue_opcode),
        .issue_robid    (issue_robid),
        .issue_pdst     (issue_pdst)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run aborted at t=%0t: %s", $time, why);
        $display("TEST FAILED");
        $fatal(1, "stopping on error");
    endtask

    // True when an enabled write port targets this register
    function automatic logic written(input int preg);
        for (int w = 0; w < NUM_WRITES; w++) begin
            if (prf_wr_en[w] && (prf_wr_preg[w] == preg)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic model_full();
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (!m_valid[e]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Advance the model across the coming edge with the inputs now driven
    task automatic model_step();
        int slot;
        int g;
        slot = -1;
        g    = -1;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (!m_valid[e] && slot < 0) begin
                slot = e;
            end
            if (!issue_stall && g < 0 && m_valid[e] && !m_pend[e][0] && !m_pend[e][1]) begin
                g = e;
            end
        end
        exp_iv = (g >= 0);
        if (g >= 0) begin
            exp_op     = m_op[g];
            exp_robid  = m_robid[g];
            exp_pdst   = m_pdst[g];
            m_valid[g] = 1'b0;
        end
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            for (int s = 0; s < NUM_SOURCES; s++) begin
                if (m_valid[e] && written(m_preg[e][s])) begin
                    m_pend[e][s] = 1'b0;
                end
            end
        end
        if (disp_valid && slot < 0) begin
            abort_run("stimulus dispatched into a full station");
        end else if (disp_valid) begin
            m_valid[slot]   = 1'b1;
            m_op[slot]      = disp_opcode;
            m_robid[slot]   = disp_robid;
            m_pdst[slot]    = disp_pdst;
            m_preg[slot][0] = disp_psrc1;
            m_preg[slot][1] = disp_psrc2;
            // Same-cycle write already satisfies the source
            m_pend[slot][0] = disp_psrc1_pend && !written(disp_psrc1);
            m_pend[slot][1] = disp_psrc2_pend && !written(disp_psrc2);
            disp_count[disp_robid]++;
            outstanding++;
        end
    endtask

    task automatic compare_outputs();
        check_value("issue_valid", exp_iv, issue_valid);
        if (issue_valid) begin
            check_value("earlier_issues_of_robid", 0, issue_count[issue_robid]);
            issue_count[issue_robid]++;
        end
        if (exp_iv) begin
            check_value("issue_opcode", exp_op, issue_opcode);
            check_value("issue_robid", exp_robid, issue_robid);
            check_value("issue_pdst", exp_pdst, issue_pdst);
            outstanding--;
        end
        check_value("rs_full", model_full(), rs_full);
    endtask

    // One clock of model step, edge, compare and strobe release
    task automatic run_cycle();
        model_step();
        @(posedge clk);
        #1;
        compare_outputs();
        #1;
        disp_valid = 1'b0;
        prf_wr_en  = '0;
    endtask

    initial begin
        int    fd;
        int    n;
        int    f [7];
        int    wait_cycles;
        string line;
        reset           = 1'b1;
        disp_valid      = 1'b0;
        disp_opcode     = op_add;
        disp_robid      = '0;
        disp_pdst       = '0;
        disp_psrc1      = '0;
        disp_psrc1_pend = 1'b0;
        disp_psrc2      = '0;
        disp_psrc2_pend = 1'b0;
        prf_wr_en       = '0;
        issue_stall     = 1'b0;
        for (int w = 0; w < NUM_WRITES; w++) begin
            prf_wr_preg[w] = '0;
        end
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            m_valid[e] = 1'b0;
            m_pend[e]  = '{1'b0, 1'b0};
        end
        for (int r = 0; r < NUM_ROBIDS; r++) begin
            disp_count[r]  = 0;
            issue_count[r] = 0;
        end
        exp_iv      = 1'b0;
        outstanding = 0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("issue_valid", 0, issue_valid);
        check_value("rs_full", 0, rs_full);

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end
        while ($fgets(line, fd)) begin
            case (line.getc(0))
                "D": begin
                    n = $sscanf(line, "D %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    if (n != 7) begin
                        abort_run({"malformed dispatch line: ", line});
                    end
                    disp_valid      = 1'b1;
                    disp_opcode     = t_opcode'(f[0]);
                    disp_robid      = f[1];
                    disp_pdst       = f[2];
                    disp_psrc1      = f[3];
                    disp_psrc1_pend = f[4];
                    disp_psrc2      = f[5];
                    disp_psrc2_pend = f[6];
                    run_cycle();
                    // Occasional idle gap after a dispatch
                    if (($random(seed) & 3) == 0) begin
                        run_cycle();
                    end
                end
                "W": begin
                    n = $sscanf(line, "W %h %h", f[0], f[1]);
                    if (n != 2 || f[0] >= NUM_WRITES) begin
                        abort_run({"malformed writeback line: ", line});
                    end
                    prf_wr_en[f[0]]   = 1'b1;
                    prf_wr_preg[f[0]] = f[1];
                end
                "S": begin
                    n = $sscanf(line, "S %h", f[0]);
                    if (n != 1) begin
                        abort_run({"malformed stall line: ", line});
                    end
                    issue_stall = f[0][0];
                end
                "F": begin
                    n = $sscanf(line, "F %h", f[0]);
                    if (n != 1) begin
                        abort_run({"malformed full line: ", line});
                    end
                    check_value("rs_full", f[0], rs_full);
                end
                "I": run_cycle();
                default: begin
                    // Comments and blank lines
                end
            endcase
        end
        $fclose(fd);

        // Drain everything still held in the station
        issue_stall = 1'b0;
        wait_cycles = 0;
        while (outstanding > 0) begin
            if (wait_cycles >= DRAIN_TIMEOUT) begin
                abort_run("timeout while waiting for outstanding issues");
            end
            run_cycle();
            wait_cycles++;
        end
        for (int r = 0; r < NUM_ROBIDS; r++) begin
            check_value("issues_per_robid", disp_count[r], issue_count[r]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tests/rs_tests.txt ====
# D op robid pdst psrc1 pend1 psrc2 pend2 : dispatch, one cycle (hex fields)
# W port preg : writeback in the next D or I cycle; S level : stall; I : idle; F level : rs_full
F 0
# Ready micro-ops
D 0 01 10 01 0 02 0
I
I
D 7 02 11 03 0 04 0
I
I
I
# Pending source waits for its write
D 1 03 12 20 1 05 0
I
I
W 1 20
I
I
I
# Writes in the dispatch cycle
W 0 21
W 1 22
D 2 04 13 21 1 22 1
I
I
I
# Fill the station with pending micro-ops
D 3 05 14 30 1 00 0
D 4 06 15 31 1 00 0
D 5 07 16 32 0 33 1
D 6 08 17 34 1 35 1
F 1
I
F 1
W 0 30
I
I
I
F 0
W 0 31
W 1 33
I
W 0 34
W 1 35
I
I
I
I
# Stall holds several ready micro-ops
S 1
D 0 09 18 01 0 02 0
D 1 0a 19 03 0 04 0
D 2 0b 1a 05 0 06 0
I
I
S 0
I
I
I
I
# Wakeup during a stall
S 1
D 3 0c 1b 3a 1 00 0
W 0 3a
I
I
S 0
I
I

// ==== filelist.f ====
source/rs_pkg.sv
source/rs_reg_trk.sv
source/rs_entry.sv
source/rs_alloc.sv
source/rs_issue_select.sv
source/rs_top.sv
tests/rs_tb.sv

// ==== Bender.yml ====
package:
  name: rs_station

sources:
  # Package first, then the RTL bottom up
  - files:
      - source/rs_pkg.sv
      - source/rs_reg_trk.sv
      - source/rs_entry.sv
      - source/rs_alloc.sv
      - source/rs_issue_select.sv
      - source/rs_top.sv

  # Testbench
  - target: test
    files:
      - tests/rs_tb.sv
